// ==== hdl/uart_gpio_pkg.sv ====
package uart_gpio_pkg;

  // --------------------------------------------------
  // Board and link sizes
  // --------------------------------------------------
  localparam int gpio_width     = 3;
  localparam int clocks_per_bit = 16; // Simulation bit time
  localparam int fifo_depth     = 8;

  // Bit timing counters
  localparam int count_width = $clog2(clocks_per_bit);
  localparam logic [count_width-1:0] mid_tick  = count_width'(clocks_per_bit / 2 - 1);
  localparam logic [count_width-1:0] last_tick = count_width'(clocks_per_bit - 1);

  // Queue pointers and occupancy
  localparam int ptr_width = $clog2(fifo_depth);
  localparam logic [ptr_width:0] full_count = (ptr_width + 1)'(fifo_depth);

  // Receiver FSM states
  localparam logic [1:0] rx_idle  = 2'd0;
  localparam logic [1:0] rx_start = 2'd1;
  localparam logic [1:0] rx_data  = 2'd2;
  localparam logic [1:0] rx_stop  = 2'd3;

  // --------------------------------------------------
  // Command byte
  // --------------------------------------------------
  typedef enum logic [1:0] {
    op_write_output = 2'd0, // Payload low bits to output register
    op_write_enable = 2'd1, // Payload low bits to enable register
    op_read_pins    = 2'd2, // Reply with pin state
    op_echo         = 2'd3  // Reply with the byte itself
  } opcode_t;

  typedef union packed {
    logic [7:0] raw;
    struct packed {
      opcode_t    opcode;
      logic [5:0] payload;
    } fields;
  } command_word;

endpackage

// ==== hdl/byte_fifo_if.sv ====
`timescale 1ns/1ns

interface byte_fifo_if;

  // Write side
  logic       push;
  logic [7:0] push_data;
  logic       full;

  // Read side
  logic       pop;
  logic [7:0] pop_data;
  logic       empty;

  modport producer (
    output push,
    output push_data,
    input  full
  );

  modport buffer (
    input  push,
    input  push_data,
    output full,
    input  pop,
    output pop_data,
    output empty
  );

  modport consumer (
    output pop,
    input  pop_data,
    input  empty
  );

endinterface

// ==== hdl/uart_receiver.sv ====
`timescale 1ns/1ns

module uart_receiver (
  input  logic         clock,
  input  logic         reset,
  input  logic         rx,
  byte_fifo_if.producer fifo
);

  logic       rx_meta;
  logic       rx_sync;
  logic       rx_prev; // For falling edge detection
  logic [1:0] state;
  logic [2:0] bit_count;
  logic [7:0] shift_reg;
  logic [uart_gpio_pkg::count_width-1:0] clock_count;

  logic sample_data;

  // Data bit sampled at its middle
  assign sample_data = (state == uart_gpio_pkg::rx_data) &&
                       (clock_count == uart_gpio_pkg::last_tick);

  assign fifo.push_data = shift_reg;

  // --------------------------------------------------
  // Synchronizer and frame FSM
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      rx_meta     <= 1'b1; // Line idles high
      rx_sync     <= 1'b1;
      rx_prev     <= 1'b1;
      state       <= uart_gpio_pkg::rx_idle;
      clock_count <= '0;
      bit_count   <= '0;
      fifo.push   <= 1'b0;
    end else begin
      rx_meta   <= rx;
      rx_sync   <= rx_meta;
      rx_prev   <= rx_sync;
      fifo.push <= 1'b0;
      case (state)
        uart_gpio_pkg::rx_idle: begin
          if (rx_prev && !rx_sync) begin
            state       <= uart_gpio_pkg::rx_start;
            clock_count <= '0;
          end
        end
        uart_gpio_pkg::rx_start: begin
          if (clock_count == uart_gpio_pkg::mid_tick) begin
            clock_count <= '0;
            bit_count   <= '0;
            // A high line here was only a glitch
            state <= rx_sync ? uart_gpio_pkg::rx_idle : uart_gpio_pkg::rx_data;
          end else begin
            clock_count <= clock_count + 1'b1;
          end
        end
        uart_gpio_pkg::rx_data: begin
          if (sample_data) begin
            clock_count <= '0;
            if (bit_count == 3'd7) begin
              state <= uart_gpio_pkg::rx_stop;
            end else begin
              bit_count <= bit_count + 1'b1;
            end
          end else begin
            clock_count <= clock_count + 1'b1;
          end
        end
        default: begin // Stop bit
          if (clock_count == uart_gpio_pkg::last_tick) begin
            fifo.push   <= rx_sync && !fifo.full; // Low stop bit drops the byte
            state       <= uart_gpio_pkg::rx_idle;
            clock_count <= '0;
          end else begin
            clock_count <= clock_count + 1'b1;
          end
        end
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clock) begin
    if (sample_data) begin
      shift_reg <= {rx_sync, shift_reg[7:1]};
    end
  end

endmodule

// ==== hdl/byte_fifo.sv ====
`timescale 1ns/1ns

module byte_fifo (
  input  logic       clock,
  input  logic       reset,
  byte_fifo_if.buffer fifo
);

  logic [7:0] mem [uart_gpio_pkg::fifo_depth];
  logic [uart_gpio_pkg::ptr_width-1:0] wr_ptr;
  logic [uart_gpio_pkg::ptr_width-1:0] rd_ptr;
  logic [uart_gpio_pkg::ptr_width:0]   count;

  logic do_push;
  logic do_pop;

  assign do_push = fifo.push && !fifo.full; // Push into a full queue is lost
  assign do_pop  = fifo.pop && !fifo.empty;

  assign fifo.full     = (count == uart_gpio_pkg::full_count);
  assign fifo.empty    = (count == '0);
  assign fifo.pop_data = mem[rd_ptr]; // Head entry

  // --------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1; // Wraps at the depth
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither
      endcase
    end
  end

  // Storage
  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= fifo.push_data;
    end
  end

endmodule

// ==== hdl/uart_transmitter.sv ====
`timescale 1ns/1ns

module uart_transmitter (
  input  logic       clock,
  input  logic       reset,
  input  logic       start,
  input  logic [7:0] data,
  output logic       busy,
  output logic       tx
);

  logic [9:0] frame;     // Stop, data, start
  logic [3:0] bit_count;
  logic [uart_gpio_pkg::count_width-1:0] clock_count;

  logic load;
  logic bit_done;

  assign load     = start && !busy;
  assign bit_done = busy && (clock_count == uart_gpio_pkg::last_tick);

  // Idle line is high
  assign tx = !busy || frame[0];

  // --------------------------------------------------
  // Bit timing
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      busy        <= 1'b0;
      bit_count   <= '0;
      clock_count <= '0;
    end else if (load) begin
      busy        <= 1'b1;
      bit_count   <= '0;
      clock_count <= '0;
    end else if (busy) begin
      if (bit_done) begin
        clock_count <= '0;
        if (bit_count == 4'd9) begin
          busy <= 1'b0; // End of stop bit
        end else begin
          bit_count <= bit_count + 1'b1;
        end
      end else begin
        clock_count <= clock_count + 1'b1;
      end
    end
  end

  // Frame shifter
  always_ff @(posedge clock) begin
    if (load) begin
      frame <= {1'b1, data, 1'b0};
    end else if (bit_done) begin
      frame <= {1'b1, frame[9:1]};
    end
  end

endmodule

// ==== hdl/gpio_command_engine.sv ====
`timescale 1ns/1ns

module gpio_command_engine (
  input  logic                               clock,
  input  logic                               reset,
  byte_fifo_if.consumer                      fifo,
  input  logic [uart_gpio_pkg::gpio_width-1:0] pin_input,
  output logic [uart_gpio_pkg::gpio_width-1:0] pin_output,
  output logic [uart_gpio_pkg::gpio_width-1:0] pin_enable,
  output logic                               tx
);

  uart_gpio_pkg::command_word head;

  logic       needs_reply;
  logic       tx_start;
  logic       tx_busy;
  logic [7:0] tx_data;

  assign head = fifo.pop_data;

  // --------------------------------------------------
  // Decode of the queue head
  // --------------------------------------------------
  always_comb begin
    case (head.fields.opcode)
      uart_gpio_pkg::op_read_pins: begin
        needs_reply = 1'b1;
        tx_data     = {{(8 - uart_gpio_pkg::gpio_width){1'b0}}, pin_input};
      end
      uart_gpio_pkg::op_echo: begin
        needs_reply = 1'b1;
        tx_data     = head.raw; // Whole byte back
      end
      default: begin
        needs_reply = 1'b0; // Writes never wait on the transmitter
        tx_data     = head.raw;
      end
    endcase
  end

  // Replies hold the head until the transmitter is free
  assign fifo.pop = !fifo.empty && !(needs_reply && tx_busy);
  assign tx_start = fifo.pop && needs_reply;

  // --------------------------------------------------
  // GPIO registers
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      pin_output <= '0;
      pin_enable <= '0; // All pins released
    end else if (fifo.pop) begin
      case (head.fields.opcode)
        uart_gpio_pkg::op_write_output: begin
          pin_output <= head.fields.payload[uart_gpio_pkg::gpio_width-1:0];
        end
        uart_gpio_pkg::op_write_enable: begin
          pin_enable <= head.fields.payload[uart_gpio_pkg::gpio_width-1:0];
        end
        default: begin
          pin_output <= pin_output;
        end
      endcase
    end
  end

  // Reply path
  uart_transmitter transmitter (
    .clock (clock),
    .reset (reset),
    .start (tx_start),
    .data  (tx_data),
    .busy  (tx_busy),
    .tx    (tx)
  );

endmodule

// ==== hdl/uart_gpio_top.sv ====
`timescale 1ns/1ns

module uart_gpio_top (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                uart_rx,
  output logic                                uart_tx,
  inout  wire [uart_gpio_pkg::gpio_width-1:0] gpio
);

  logic reset_q; // Internal reset one cycle behind the pin

  logic [uart_gpio_pkg::gpio_width-1:0] pin_input;
  logic [uart_gpio_pkg::gpio_width-1:0] pin_output;
  logic [uart_gpio_pkg::gpio_width-1:0] pin_enable;

  always_ff @(posedge clock) begin
    reset_q <= reset;
  end

  // --------------------------------------------------
  // Tristate pads
  // --------------------------------------------------
  for (genvar i = 0; i < uart_gpio_pkg::gpio_width; i++) begin : g_pad
    assign gpio[i]      = pin_enable[i] ? pin_output[i] : 1'bz;
    assign pin_input[i] = pin_enable[i] ? pin_output[i] : gpio[i]; // Driven pins read own value
  end

  byte_fifo_if fifo_bus ();

  uart_receiver receiver (
    .clock (clock),
    .reset (reset_q),
    .rx    (uart_rx),
    .fifo  (fifo_bus.producer)
  );

  byte_fifo queue (
    .clock (clock),
    .reset (reset_q),
    .fifo  (fifo_bus.buffer)
  );

  gpio_command_engine engine (
    .clock      (clock),
    .reset      (reset_q),
    .fifo       (fifo_bus.consumer),
    .pin_input  (pin_input),
    .pin_output (pin_output),
    .pin_enable (pin_enable),
    .tx         (uart_tx)
  );

endmodule

// ==== verif/uart_serial_bfm.svh ====
`ifndef UART_SERIAL_BFM_SVH
`define UART_SERIAL_BFM_SVH

// --------------------------------------------------
// Serial line tasks at the package bit time
// --------------------------------------------------

// Start bit, eight data bits LSB first, stop bit
task automatic send_byte(input logic [7:0] value, input logic bad_stop);
  logic [9:0] frame;
  frame = {!bad_stop, value, 1'b0};
  for (int i = 0; i < 10; i++) begin
    @(posedge clock);
    uart_rx <= frame[i];
    repeat (uart_gpio_pkg::clocks_per_bit - 1) @(posedge clock);
  end
  if (bad_stop) begin
    @(posedge clock);
    uart_rx <= 1'b1; // Back to idle so the next start edge is seen
    repeat (uart_gpio_pkg::clocks_per_bit - 1) @(posedge clock);
  end
endtask

// Waits for a start bit, then samples each bit near its middle
task automatic capture_byte(input int wait_limit, output logic [7:0] value,
                            output logic seen);
  int waited;
  waited = 0;
  value  = '0;
  seen   = 1'b0;
  @(negedge clock);
  while (uart_tx !== 1'b0 && waited < wait_limit) begin
    @(negedge clock);
    waited++;
  end
  if (uart_tx === 1'b0) begin
    seen = 1'b1;
    repeat (uart_gpio_pkg::clocks_per_bit / 2) @(negedge clock); // Middle of start bit
    for (int i = 0; i < 8; i++) begin
      repeat (uart_gpio_pkg::clocks_per_bit) @(negedge clock);
      value[i] = uart_tx;
    end
    repeat (uart_gpio_pkg::clocks_per_bit) @(negedge clock);
    check_value("uart_tx stop bit", 32'(uart_tx), 32'd1);
  end
endtask

`endif

// ==== verif/uart_gpio_tb.sv ====
`timescale 1ns/1ns

module uart_gpio_tb;

  typedef struct packed {
    logic [7:0]                           command;
    logic                                 bad_stop;
    logic [uart_gpio_pkg::gpio_width-1:0] drive;
    logic                                 burst_end; // Pins checked after this entry
  } stim_t;

  logic clock;
  logic reset;
  logic uart_rx;
  wire  uart_tx;
  wire  [uart_gpio_pkg::gpio_width-1:0] gpio;

  logic [uart_gpio_pkg::gpio_width-1:0] pin_drive;
  logic [uart_gpio_pkg::gpio_width-1:0] pin_release;
  logic [uart_gpio_pkg::gpio_width-1:0] model_output; // Reference registers
  logic [uart_gpio_pkg::gpio_width-1:0] model_enable;

  stim_t      stim_table[$];
  logic [7:0] expected_replies[$];
  int         seed = 32'h61b9_4ff1;
  int         first;
  logic       table_ready = 1'b0;

  uart_gpio_top DUT (
    .clock   (clock),
    .reset   (reset),
    .uart_rx (uart_rx),
    .uart_tx (uart_tx),
    .gpio    (gpio)
  );

  // Board side pin drivers
  for (genvar i = 0; i < uart_gpio_pkg::gpio_width; i++) begin : g_drive
    assign gpio[i] = pin_release[i] ? 1'bz : pin_drive[i];
  end

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // --------------------------------------------------
  // Failure reporting and checks
  // --------------------------------------------------
  task automatic stop_on_failure(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at %0t", $time);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
      stop_on_failure("Stopping on the first mismatch");
    end
  endtask

  `include "uart_serial_bfm.svh"

  // Enabled pins show the output register, released pins the board drive
  function automatic logic [uart_gpio_pkg::gpio_width-1:0] expected_pins(
    input logic [uart_gpio_pkg::gpio_width-1:0] drive);
    return (model_output & model_enable) | (drive & ~model_enable);
  endfunction

  task automatic apply_model(input logic [7:0] command,
                             input logic [uart_gpio_pkg::gpio_width-1:0] drive);
    uart_gpio_pkg::command_word cmd;
    cmd.raw = command;
    case (cmd.fields.opcode)
      uart_gpio_pkg::op_write_output: model_output = cmd.fields.payload[2:0];
      uart_gpio_pkg::op_write_enable: model_enable = cmd.fields.payload[2:0];
      uart_gpio_pkg::op_read_pins:    expected_replies.push_back(8'(expected_pins(drive)));
      default:                        expected_replies.push_back(cmd.raw); // Echo
    endcase
  endtask

  task automatic build_table();
    stim_t entry;
    logic [uart_gpio_pkg::gpio_width-1:0] burst_drive;
    stim_table.push_back('{8'h43, 1'b0, 3'b101, 1'b1}); // Enable pins 0 and 1
    stim_table.push_back('{8'h02, 1'b0, 3'b101, 1'b1}); // Output 010
    stim_table.push_back('{8'h80, 1'b0, 3'b110, 1'b1}); // Read with mixed enables
    stim_table.push_back('{8'hC5, 1'b0, 3'b110, 1'b1}); // Echo
    stim_table.push_back('{8'h07, 1'b1, 3'b110, 1'b1}); // Write dropped by low stop
    stim_table.push_back('{8'h80, 1'b0, 3'b001, 1'b1});
    stim_table.push_back('{8'hE1, 1'b1, 3'b001, 1'b1}); // Echo dropped so no reply
    stim_table.push_back('{8'h80, 1'b0, 3'b100, 1'b1});
    burst_drive = '0;
    for (int k = 0; k < 20; k++) begin
      if (k % (uart_gpio_pkg::fifo_depth / 2) == 0) begin
        burst_drive = 3'($random(seed)); // One board drive per burst
      end
      entry.command   = 8'($random(seed));
      entry.bad_stop  = 1'b0;
      entry.drive     = burst_drive;
      entry.burst_end = (k % (uart_gpio_pkg::fifo_depth / 2)) ==
                        (uart_gpio_pkg::fifo_depth / 2 - 1);
      stim_table.push_back(entry);
    end
  endtask

  // --------------------------------------------------
  // Burst of back-to-back commands with reply capture
  // --------------------------------------------------
  task automatic send_entries(input int from, input int to);
    for (int i = from; i <= to; i++) begin
      send_byte(stim_table[i].command, stim_table[i].bad_stop);
      if (!stim_table[i].bad_stop) begin
        apply_model(stim_table[i].command, stim_table[i].drive);
      end
      pin_release <= model_enable;
    end
  endtask

  task automatic collect_replies(input int count, input int wait_limit);
    logic [7:0] value;
    logic       seen;
    for (int i = 0; i < count; i++) begin
      capture_byte(wait_limit, value, seen);
      if (!seen) begin
        stop_on_failure("No reply byte appeared on uart_tx");
      end
      check_value("reply byte", 32'(value), 32'(expected_replies.pop_front()));
    end
  endtask

  task automatic run_burst(input int from, input int to);
    uart_gpio_pkg::command_word cmd;
    int replies;
    replies = 0;
    for (int i = from; i <= to; i++) begin
      cmd.raw = stim_table[i].command;
      if (!stim_table[i].bad_stop && (cmd.fields.opcode == uart_gpio_pkg::op_read_pins ||
                                      cmd.fields.opcode == uart_gpio_pkg::op_echo)) begin
        replies++;
      end
    end
    @(posedge clock);
    pin_drive <= stim_table[from].drive;
    fork
      send_entries(from, to);
      collect_replies(replies, (to - from + 2) * 12 * uart_gpio_pkg::clocks_per_bit);
    join
    // Line stays idle for one bit time once the expected replies are in
    for (int n = 0; n < uart_gpio_pkg::clocks_per_bit; n++) begin
      @(negedge clock);
      check_value("uart_tx idle", 32'(uart_tx), 32'd1);
    end
    check_value("gpio", 32'(gpio), 32'(expected_pins(pin_drive)));
  endtask

  initial begin
    reset        = 1'b1;
    uart_rx      = 1'b1; // Idle line
    pin_drive    = 3'b011;
    pin_release  = '0;
    model_output = '0;
    model_enable = '0;
    build_table();
    table_ready = 1'b1;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    check_value("uart_tx", 32'(uart_tx), 32'd1);
    check_value("gpio", 32'(gpio), 32'(pin_drive));

    first = 0;
    for (int i = 0; i < stim_table.size(); i++) begin
      if (stim_table[i].burst_end) begin
        run_burst(first, i);
        first = i + 1;
      end
    end

    $display("Simulation finished: PASS");
    $finish;
  end

  // Watchdog of 30 bit times per table entry
  initial begin : watchdog
    int limit;
    wait (table_ready);
    limit = stim_table.size() * 30 * uart_gpio_pkg::clocks_per_bit + 20;
    repeat (limit) @(posedge clock);
    stop_on_failure($sformatf("Watchdog expired after %0d cycles", limit));
  end

endmodule

// ==== src.f ====
+incdir+verif
hdl/uart_gpio_pkg.sv
hdl/byte_fifo_if.sv
hdl/uart_receiver.sv
hdl/byte_fifo.sv
hdl/uart_transmitter.sv
hdl/gpio_command_engine.sv
hdl/uart_gpio_top.sv
verif/uart_gpio_tb.sv

// ==== Makefile ====
# Verilator simulation of the UART GPIO controller

VERILATOR ?= verilator
TOP       ?= uart_gpio_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard verif/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
